// File: rv_wb_pkg.sv
`default_nettype none

package rv_wb_pkg;

    // ****************************************
    // Basic types
    // ****************************************

    typedef logic [31:0] word_t;     // RV32 architectural word.
    typedef logic [6:0]  opcode_t;   // Instruction bits [6:0].
    typedef logic [4:0]  reg_addr_t; // Register index x0..x31.

    // ****************************************
    // RV32I base opcodes
    // ****************************************

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // ****************************************
    // Writeback select
    // ****************************************

    // Source of the word written back to rd.
    typedef enum logic [1:0] {
        WB_MEM = 2'b00, // Load data.
        WB_ALU = 2'b01, // ALU result.
        WB_PC4 = 2'b10, // Link address.
        WB_RSV = 2'b11  // Reserved.
    } wb_sel_e;

endpackage

`default_nettype wire

// File: mem_access_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   ex_valid,
    input  wire rv_wb_pkg::word_t ex_instr,
    input  wire rv_wb_pkg::word_t ex_pc_4,
    input  wire rv_wb_pkg::word_t ex_alu_out,
    input  wire rv_wb_pkg::word_t ex_store_data,
    output logic                  acc_valid,
    output rv_wb_pkg::word_t      acc_instr,
    output rv_wb_pkg::word_t      acc_pc_4,
    output rv_wb_pkg::word_t      acc_alu_out,
    output rv_wb_pkg::word_t      acc_dmem_out
);

    import rv_wb_pkg::*;

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    word_t             dmem [DMEM_WORDS];
    opcode_t           ex_opcode;
    logic [ADDR_W-1:0] dmem_addr;
    logic              ex_is_load;
    logic              ex_is_store;

    assign ex_opcode = ex_instr[6:0];

    // Word address taken from the ALU result.
    assign dmem_addr = ex_alu_out[ADDR_W+1:2];

    assign ex_is_load  = ex_valid && (ex_opcode == OPC_LOAD);
    assign ex_is_store = ex_valid && (ex_opcode == OPC_STORE);

    // ****************************************
    // Data memory
    // ****************************************

    always_ff @(posedge clk) begin
        if (ex_is_store) begin
            dmem[dmem_addr] <= ex_store_data;
        end
    end

    // ****************************************
    // Memory to writeback pipeline register
    // ****************************************

    // Read happens every cycle. Only loads use the result downstream.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc_valid    <= 1'b0;
            acc_instr    <= '0;
            acc_pc_4     <= '0;
            acc_alu_out  <= '0;
            acc_dmem_out <= '0;
        end else begin
            acc_valid    <= ex_valid;
            acc_instr    <= ex_instr;
            acc_pc_4     <= ex_pc_4;
            acc_alu_out  <= ex_alu_out;
            acc_dmem_out <= dmem[dmem_addr]; // Lines up with the fields above.
        end
    end

    // Upper address bits are dropped by the index, so an access past the
    // end would silently alias onto a lower word.
    a_dmem_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (ex_is_load || ex_is_store) |-> (ex_alu_out[31:2] < DMEM_WORDS)
    ) else $error("data memory access outside DMEM_WORDS");

endmodule

`default_nettype wire

// File: wb_ctl.sv
`timescale 1ns/100ps
`default_nettype none

module wb_ctl (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    acc_valid,
    input  wire rv_wb_pkg::word_t  acc_instr,
    input  wire rv_wb_pkg::word_t  acc_pc_4,
    input  wire rv_wb_pkg::word_t  acc_alu_out,
    input  wire rv_wb_pkg::word_t  acc_dmem_out,
    output rv_wb_pkg::wb_sel_e     wb_sel,
    output logic                   reg_wen,
    output rv_wb_pkg::reg_addr_t   wb_rd,
    output rv_wb_pkg::word_t       pc_4_wb,
    output rv_wb_pkg::word_t       alu_out_wb,
    output rv_wb_pkg::word_t       dmem_out_wb
);

    import rv_wb_pkg::*;

    opcode_t acc_opcode;
    wb_sel_e dec_sel;
    logic    dec_wen;

    assign acc_opcode = acc_instr[6:0];

    // ****************************************
    // Opcode decode
    // ****************************************

    always_comb begin
        dec_sel = WB_MEM;
        dec_wen = 1'b0;
        case (acc_opcode)
            OPC_LUI, OPC_AUIPC: begin
                dec_sel = WB_ALU;
                dec_wen = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                dec_sel = WB_PC4;
                dec_wen = 1'b1;
            end
            OPC_LOAD: begin
                dec_sel = WB_MEM;
                dec_wen = 1'b1;
            end
            OPC_OP_IMM, OPC_OP: begin
                dec_sel = WB_ALU;
                dec_wen = 1'b1;
            end
            // Branches and stores have no destination register.
            default: begin
                dec_sel = WB_MEM;
                dec_wen = 1'b0;
            end
        endcase
    end

    // ****************************************
    // Writeback pipeline register
    // ****************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_sel      <= WB_MEM;
            reg_wen     <= 1'b0;
            wb_rd       <= '0;
            pc_4_wb     <= '0;
            alu_out_wb  <= '0;
            dmem_out_wb <= '0;
        end else begin
            wb_sel      <= dec_sel;
            reg_wen     <= dec_wen && acc_valid; // Bubbles never write.
            wb_rd       <= acc_instr[11:7];
            pc_4_wb     <= acc_pc_4;
            alu_out_wb  <= acc_alu_out;
            dmem_out_wb <= acc_dmem_out;
        end
    end

    a_no_reserved_sel: assert property (
        @(posedge clk) disable iff (rst)
        reg_wen |-> (wb_sel != WB_RSV)
    ) else $error("register write with reserved writeback select");

endmodule

`default_nettype wire

// File: reg_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module reg_writeback (
    input  wire                        clk,
    input  wire                        rst,
    input  wire rv_wb_pkg::wb_sel_e    wb_sel,
    input  wire                        reg_wen,
    input  wire rv_wb_pkg::reg_addr_t  wb_rd,
    input  wire rv_wb_pkg::word_t      pc_4_wb,
    input  wire rv_wb_pkg::word_t      alu_out_wb,
    input  wire rv_wb_pkg::word_t      dmem_out_wb,
    input  wire rv_wb_pkg::reg_addr_t  rs1_addr,
    input  wire rv_wb_pkg::reg_addr_t  rs2_addr,
    output logic                       wb_we,
    output rv_wb_pkg::reg_addr_t       wb_rd_out,
    output rv_wb_pkg::word_t           wb_data,
    output rv_wb_pkg::word_t           rs1_data,
    output rv_wb_pkg::word_t           rs2_data
);

    import rv_wb_pkg::*;

    word_t regs [1:31]; // x0 has no storage.

    // x0 is hardwired to zero.
    function automatic word_t read_reg(input reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    // ****************************************
    // Writeback select
    // ****************************************

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_out_wb;
            WB_ALU:  wb_data = alu_out_wb;
            WB_PC4:  wb_data = pc_4_wb;
            default: wb_data = '0;
        endcase
    end

    assign wb_we     = reg_wen && (wb_rd != '0);
    assign wb_rd_out = wb_rd;

    // ****************************************
    // Register file
    // ****************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // No bypass. A same-cycle read of rd returns the old value.
    assign rs1_data = read_reg(rs1_addr);
    assign rs2_data = read_reg(rs2_addr);

    a_sel_known: assert property (
        @(posedge clk) disable iff (rst)
        reg_wen |-> !$isunknown(wb_sel)
    ) else $error("writeback select unknown during register write");

endmodule

`default_nettype wire

// File: rv_wb_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_wb_top #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        ex_valid,
    input  wire rv_wb_pkg::word_t      ex_instr,
    input  wire rv_wb_pkg::word_t      ex_pc_4,
    input  wire rv_wb_pkg::word_t      ex_alu_out,
    input  wire rv_wb_pkg::word_t      ex_store_data,
    input  wire rv_wb_pkg::reg_addr_t  rs1_addr,
    input  wire rv_wb_pkg::reg_addr_t  rs2_addr,
    output logic                       wb_we,
    output rv_wb_pkg::reg_addr_t       wb_rd_out,
    output rv_wb_pkg::word_t           wb_data,
    output rv_wb_pkg::word_t           rs1_data,
    output rv_wb_pkg::word_t           rs2_data
);

    import rv_wb_pkg::*;

    // Memory stage outputs.
    logic      acc_valid;
    word_t     acc_instr;
    word_t     acc_pc_4;
    word_t     acc_alu_out;
    word_t     acc_dmem_out;

    // Writeback register outputs.
    wb_sel_e   wb_sel;
    logic      reg_wen;
    reg_addr_t wb_rd;
    word_t     pc_4_wb;
    word_t     alu_out_wb;
    word_t     dmem_out_wb;

    mem_access_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_mem_access_stage (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_instr      (ex_instr),
        .ex_pc_4       (ex_pc_4),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .acc_valid     (acc_valid),
        .acc_instr     (acc_instr),
        .acc_pc_4      (acc_pc_4),
        .acc_alu_out   (acc_alu_out),
        .acc_dmem_out  (acc_dmem_out)
    );

    wb_ctl i_wb_ctl (
        .clk          (clk),
        .rst          (rst),
        .acc_valid    (acc_valid),
        .acc_instr    (acc_instr),
        .acc_pc_4     (acc_pc_4),
        .acc_alu_out  (acc_alu_out),
        .acc_dmem_out (acc_dmem_out),
        .wb_sel       (wb_sel),
        .reg_wen      (reg_wen),
        .wb_rd        (wb_rd),
        .pc_4_wb      (pc_4_wb),
        .alu_out_wb   (alu_out_wb),
        .dmem_out_wb  (dmem_out_wb)
    );

    reg_writeback i_reg_writeback (
        .clk         (clk),
        .rst         (rst),
        .wb_sel      (wb_sel),
        .reg_wen     (reg_wen),
        .wb_rd       (wb_rd),
        .pc_4_wb     (pc_4_wb),
        .alu_out_wb  (alu_out_wb),
        .dmem_out_wb (dmem_out_wb),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .wb_we       (wb_we),
        .wb_rd_out   (wb_rd_out),
        .wb_data     (wb_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

endmodule

`default_nettype wire

// File: rv_wb_tb_model.svh
`ifndef RV_WB_TB_MODEL_SVH
`define RV_WB_TB_MODEL_SVH

// Reference model of the memory stage and the register file.
word_t model_dmem   [DMEM_WORDS];
logic  dmem_written [DMEM_WORDS]; // Memory has no reset, so unwritten words are unknown.
word_t model_regs   [32];
logic  reg_known    [32];

// Opcodes with a destination register.
function automatic logic writes_reg(input opcode_t opc);
    case (opc)
        OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: return 1'b1;
        OPC_LOAD, OPC_OP_IMM, OPC_OP:          return 1'b1;
        default:                               return 1'b0;
    endcase
endfunction

function automatic wb_sel_e select_for(input opcode_t opc);
    case (opc)
        OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP: return WB_ALU;
        OPC_JAL, OPC_JALR:                      return WB_PC4;
        default:                                return WB_MEM;
    endcase
endfunction

function automatic word_t writeback_word(input wb_sel_e sel, input word_t alu,
                                         input word_t pc4, input word_t mem);
    case (sel)
        WB_ALU:  return alu;
        WB_PC4:  return pc4;
        default: return mem;
    endcase
endfunction

function automatic void model_reset();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
        reg_known[i]  = 1'b1;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem_written[i] = 1'b0;
    end
endfunction

function automatic void store_word(input int widx, input word_t data);
    model_dmem[widx]   = data;
    dmem_written[widx] = 1'b1;
endfunction

function automatic void write_reg(input reg_addr_t rd, input word_t data, input logic known);
    if (rd != '0) begin // x0 stays zero.
        model_regs[rd] = data;
        reg_known[rd]  = known;
    end
endfunction

`endif

// File: rv_wb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv_wb_tb;

    import rv_wb_pkg::*;

    localparam int DMEM_WORDS     = 64;
    localparam int RESET_CYCLES   = 16;
    localparam int N_BURSTS       = 4;
    localparam int BURST_LEN      = 64;
    localparam int DRAIN          = 4;
    localparam int STIM_CYCLES    = RESET_CYCLES + 8 + N_BURSTS * BURST_LEN
                                    + (N_BURSTS + 2) * (DRAIN + 32);
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
        logic      chk; // Data is known and compared.
    } exp_t;

    logic      clk;
    logic      rst;
    logic      ex_valid;
    word_t     ex_instr;
    word_t     ex_pc_4;
    word_t     ex_alu_out;
    word_t     ex_store_data;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      wb_we;
    reg_addr_t wb_rd_out;
    word_t     wb_data;
    word_t     rs1_data;
    word_t     rs2_data;

    exp_t        exp_q [$];
    logic [31:0] lfsr_state   = 32'h634b_f5e8;
    int          value_errors = 0;
    int          checks       = 0;
    int          cycle_count  = 0;

    `include "rv_wb_tb_model.svh"

    rv_wb_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_rv_wb_top (
        .clk           (clk),
        .rst           (rst),
        .ex_valid      (ex_valid),
        .ex_instr      (ex_instr),
        .ex_pc_4       (ex_pc_4),
        .ex_alu_out    (ex_alu_out),
        .ex_store_data (ex_store_data),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .wb_we         (wb_we),
        .wb_rd_out     (wb_rd_out),
        .wb_data       (wb_data),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ****************************************
    // Random source
    // ****************************************

    function automatic logic lfsr_bit();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic opcode_t pick_opcode(input int idx);
        case (idx)
            0:       return OPC_LUI;
            1:       return OPC_AUIPC;
            2:       return OPC_JAL;
            3:       return OPC_JALR;
            4:       return OPC_BRANCH;
            5:       return OPC_LOAD;
            6:       return OPC_STORE;
            7:       return OPC_OP_IMM;
            8:       return OPC_OP;
            default: return 7'b0001111; // MISC-MEM, not decoded.
        endcase
    endfunction

    // ****************************************
    // Compare tasks
    // ****************************************

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // ****************************************
    // Stimulus
    // ****************************************

    task automatic drive(input logic valid, input opcode_t opc, input reg_addr_t rd,
                         input word_t alu, input word_t store_data);
        word_t upper;
        upper = rand_bits(20);
        @(posedge clk);
        ex_valid      <= valid;
        ex_instr      <= {upper[19:0], rd, opc};
        ex_pc_4       <= rand_bits(32);
        ex_alu_out    <= alu;
        ex_store_data <= store_data;
    endtask

    task automatic random_cycle(input logic all_valid);
        logic    valid;
        opcode_t opc;
        word_t   r;
        word_t   rd_bits;
        word_t   alu;
        r       = rand_bits(2);
        valid   = all_valid || (r != 0); // Three cycles in four carry an instruction.
        r       = rand_bits(4);
        opc     = pick_opcode(r % 10);
        rd_bits = rand_bits(5);
        if (opc == OPC_LOAD || opc == OPC_STORE) begin
            alu = rand_bits(3) << 2; // Eight words, so loads often hit earlier stores.
        end else begin
            alu = rand_bits(32);
        end
        drive(valid, opc, rd_bits[4:0], alu, rand_bits(32));
    endtask

    task automatic drain();
        repeat (DRAIN) drive(1'b0, OPC_LUI, 5'd3, rand_bits(32), rand_bits(32));
    endtask

    // Walks rs1 up and rs2 down across the whole register file.
    task automatic sweep_regs();
        reg_addr_t a1;
        reg_addr_t a2;
        for (int i = 0; i < 32; i++) begin
            a1 = i;
            a2 = 31 - i;
            @(posedge clk);
            rs1_addr <= a1;
            rs2_addr <= a2;
            @(negedge clk);
            if (reg_known[a1]) check_word($sformatf("rs1_data x%0d", a1), model_regs[a1], rs1_data);
            if (reg_known[a2]) check_word($sformatf("rs2_data x%0d", a2), model_regs[a2], rs2_data);
        end
    endtask

    // ****************************************
    // Expected writeback and compare
    // ****************************************

    // Inputs seen at this falling edge show up on the writeback ports two cycles later.
    always @(negedge clk) begin
        exp_t    cur;
        exp_t    due;
        opcode_t opc;
        word_t   mem;
        int      widx;
        if (!rst) begin
            opc     = ex_instr[6:0];
            widx    = ex_alu_out[31:2];
            mem     = '0;
            cur.rd  = ex_instr[11:7];
            cur.we  = ex_valid && writes_reg(opc) && (cur.rd != '0);
            cur.chk = 1'b1;
            if (opc == OPC_LOAD) begin
                mem     = model_dmem[widx];
                cur.chk = dmem_written[widx];
            end
            cur.data = writeback_word(select_for(opc), ex_alu_out, ex_pc_4, mem);
            if (ex_valid && opc == OPC_STORE) store_word(widx, ex_store_data);
            if (cur.we) write_reg(cur.rd, cur.data, cur.chk);
            if (exp_q.size() == 2) begin
                due = exp_q.pop_front();
                check_bit("wb_we", due.we, wb_we);
                if (due.we) begin
                    check_addr("wb_rd_out", due.rd, wb_rd_out);
                    if (due.chk) check_word("wb_data", due.data, wb_data);
                end
            end else begin
                check_bit("wb_we", 1'b0, wb_we); // Pipe still empty after reset.
            end
            exp_q.push_back(cur);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timed out after %0d cycles before the stimulus finished", cycle_count);
            $display("Errors: %0d mismatches in %0d checks", value_errors, checks);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        rst           <= 1'b1;
        ex_valid      <= 1'b0;
        ex_instr      <= '0;
        ex_pc_4       <= '0;
        ex_alu_out    <= '0;
        ex_store_data <= '0;
        rs1_addr      <= '0;
        rs2_addr      <= '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        sweep_regs();

        // Store, then loads of the same word on the next cycles.
        drive(1'b1, OPC_STORE, 5'd7, 32'h0000_0010, 32'hcafe_0123);
        drive(1'b1, OPC_LOAD, 5'd5, 32'h0000_0010, rand_bits(32));
        drive(1'b1, OPC_LOAD, 5'd0, 32'h0000_0010, rand_bits(32));
        drive(1'b1, OPC_JAL, 5'd1, rand_bits(32), rand_bits(32));
        drain();
        sweep_regs();

        for (int b = 0; b < N_BURSTS; b++) begin
            for (int c = 0; c < BURST_LEN; c++) begin
                random_cycle(b == 0); // First burst issues every cycle.
            end
            drain();
            sweep_regs();
        end

        $display("Errors: %0d mismatches in %0d checks", value_errors, checks);
        if (value_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_wb_top.f
+incdir+.
rv_wb_pkg.sv
mem_access_stage.sv
wb_ctl.sv
reg_writeback.sv
rv_wb_top.sv
rv_wb_tb.sv

// File: Bender.yml
package:
  name: rv_wb

sources:
  - files:
      - rv_wb_pkg.sv
      - mem_access_stage.sv
      - wb_ctl.sv
      - reg_writeback.sv
      - rv_wb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_wb_tb.sv
